// File: logic/dcache_macros.svh
//////////////////////////////
// Widths of data, address and
// page offset fields, cache sets
// and replay FIFO depth
//////////////////////////////

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

`define DWORD_WIDTH       64
`define PADDR_WIDTH       32
`define PAGE_OFFSET_WIDTH 12
`define PTAG_WIDTH        20
`define INDEX_WIDTH       9
`define OFFSET_WIDTH      3
`define REPLAY_ELS        8

`endif

// File: logic/dcache_pkg.sv
//////////////////////////////
// Processor side types
// Cache opcode and cache packet
//////////////////////////////

`include "dcache_macros.svh"

package dcache_pkg;

   // Load or store of one dword
   typedef enum logic
   {
      DCACHE_OP_LD = 1'b0,
      DCACHE_OP_SD = 1'b1
   } dcache_op_e;

   // One operation as it enters the replay FIFO
   typedef struct packed
   {
      dcache_op_e                     opcode;
      logic [`PAGE_OFFSET_WIDTH-1:0]  page_offset;
      logic [`DWORD_WIDTH-1:0]        data;
   } dcache_pkt_s;

endpackage

// File: logic/mem_pkg.sv
//////////////////////////////
// Memory side types
// Opcode, address union, header
//////////////////////////////

`include "dcache_macros.svh"

package mem_pkg;

   typedef enum logic
   {
      MEM_OP_RD = 1'b0,
      MEM_OP_WR = 1'b1
   } mem_op_e;

   typedef struct packed
   {
      logic [`PTAG_WIDTH-1:0]   ptag;
      logic [`INDEX_WIDTH-1:0]  index;
      logic [`OFFSET_WIDTH-1:0] offset;
   } mem_paddr_fields_s;

   // Built as fields by the engine, read raw by the memory
   typedef union packed
   {
      logic [`PADDR_WIDTH-1:0] raw;
      mem_paddr_fields_s       fields;
   } mem_paddr_u;

   typedef struct packed
   {
      mem_op_e    op;
      mem_paddr_u addr;
   } mem_header_s;

endpackage

// File: logic/replay_fifo.sv
//////////////////////////////
// Replay FIFO with write, issue
// and retire pointers, rollback
//////////////////////////////

`timescale 1ns/1ps
`include "dcache_macros.svh"

module replay_fifo
   import dcache_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,

   input  dcache_pkt_s             pkt_i,
   input  logic [`PTAG_WIDTH-1:0]  ptag_i,
   input  logic                    v_i,
   output logic                    ready_o,

   output dcache_pkt_s             pkt_o,
   output logic [`PTAG_WIDTH-1:0]  ptag_o,
   output logic                    issue_o,
   input  logic                    issue_ready_i,

   input  logic                    retire_i,
   input  logic                    roll_i
);

   // Extra wrap bit tells full from empty
   localparam int PTR_W = $clog2(`REPLAY_ELS) + 1;

   dcache_pkt_s              pkt_mem  [`REPLAY_ELS];
   logic [`PTAG_WIDTH-1:0]   ptag_mem [`REPLAY_ELS];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] iss_ptr;
   logic [PTR_W-1:0] ret_ptr;
   logic [PTR_W-1:0] used;
   logic             enq;

   assign used    = wr_ptr - ret_ptr;
   assign ready_o = (used != PTR_W'(`REPLAY_ELS));
   assign enq     = v_i & ready_o;

   // Rollback wins over issue
   assign issue_o = (iss_ptr != wr_ptr) & issue_ready_i & ~roll_i;
   assign pkt_o   = pkt_mem[iss_ptr[PTR_W-2:0]];
   assign ptag_o  = ptag_mem[iss_ptr[PTR_W-2:0]];

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr  <= '0;
         iss_ptr <= '0;
         ret_ptr <= '0;
      end
      else
      begin
         if (enq)
            wr_ptr <= wr_ptr + 1'b1;
         if (roll_i)
            iss_ptr <= ret_ptr;
         else if (issue_o)
            iss_ptr <= iss_ptr + 1'b1;
         if (retire_i)
            ret_ptr <= ret_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         pkt_mem[wr_ptr[PTR_W-2:0]]  <= pkt_i;
         ptag_mem[wr_ptr[PTR_W-2:0]] <= ptag_i;
      end
   end

endmodule

// File: logic/dcache.sv
//////////////////////////////
// Direct mapped data cache
// Tag lookup and tag verify
// Miss and store requests
//////////////////////////////

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache
   import dcache_pkg::*, mem_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   input  dcache_pkt_s              pkt_i,
   input  logic                     v_i,
   output logic                     ready_o,
   input  logic [`PTAG_WIDTH-1:0]   ptag_i,

   output logic [`DWORD_WIDTH-1:0]  data_o,
   output logic                     v_o,

   input  logic                     engine_busy_i,
   output logic                     miss_v_o,
   output mem_paddr_u               miss_paddr_o,
   output logic                     store_v_o,
   output mem_paddr_u               store_paddr_o,
   output logic [`DWORD_WIDTH-1:0]  store_data_o,
   input  logic                     fill_v_i,
   input  logic [`DWORD_WIDTH-1:0]  fill_data_i
);

   localparam int SETS = 2 ** `INDEX_WIDTH;

   logic [`PTAG_WIDTH-1:0]  tag_mem  [SETS];
   logic [`DWORD_WIDTH-1:0] data_mem [SETS];
   logic [SETS-1:0]         valid_r;

   logic                     tl_v_r;
   dcache_pkt_s              tl_pkt_r;
   logic [`INDEX_WIDTH-1:0]  tl_index;
   logic [`DWORD_WIDTH-1:0]  tl_rd_data;

   logic                     tv_v_r;
   dcache_op_e               tv_op_r;
   logic [`INDEX_WIDTH-1:0]  tv_index_r;
   logic [`OFFSET_WIDTH-1:0] tv_offset_r;
   logic [`PTAG_WIDTH-1:0]   tv_ptag_r;
   logic [`PTAG_WIDTH-1:0]   tv_tag_r;
   logic                     tv_valid_r;
   logic [`DWORD_WIDTH-1:0]  tv_data_r;
   logic [`DWORD_WIDTH-1:0]  tv_store_data_r;

   logic       pending_r;
   mem_paddr_u miss_paddr_r;
   logic       tv_ld;
   logic       tv_sd;
   logic       hit;
   logic       store_hit;
   logic       kill;

   assign tl_index = tl_pkt_r.page_offset[`PAGE_OFFSET_WIDTH-1:`OFFSET_WIDTH];

   // Forward a store hit to a younger load of the same set
   assign tl_rd_data = (store_hit && (tv_index_r == tl_index)) ? tv_store_data_r
                                                               : data_mem[tl_index];

   assign tv_ld     = tv_v_r & (tv_op_r == DCACHE_OP_LD);
   assign tv_sd     = tv_v_r & (tv_op_r == DCACHE_OP_SD);
   assign hit       = tv_valid_r & (tv_tag_r == tv_ptag_r);
   assign store_hit = store_v_o & hit;

   assign v_o       = (tv_ld & hit) | (tv_sd & ~engine_busy_i);
   assign data_o    = tv_sd ? '0 : tv_data_r;
   assign miss_v_o  = tv_ld & ~hit & ~engine_busy_i;
   assign store_v_o = tv_sd & ~engine_busy_i;
   assign ready_o   = ~engine_busy_i & ~pending_r;

   // No result in tag verify drops the op behind it
   assign kill = tv_v_r & ~v_o;

   assign miss_paddr_o.fields  = '{ptag: tv_ptag_r, index: tv_index_r, offset: '0};
   assign store_paddr_o.fields = '{ptag: tv_ptag_r, index: tv_index_r, offset: tv_offset_r};
   assign store_data_o         = tv_store_data_r;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         tl_v_r    <= 1'b0;
         tv_v_r    <= 1'b0;
         pending_r <= 1'b0;
         valid_r   <= '0;
      end
      else
      begin
         tl_v_r <= v_i;
         tv_v_r <= tl_v_r & ~kill;
         if (fill_v_i)
         begin
            pending_r                              <= 1'b0;
            valid_r[miss_paddr_r.fields.index] <= 1'b1;
         end
         else if (miss_v_o)
            pending_r <= 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      tl_pkt_r        <= pkt_i;
      tv_op_r         <= tl_pkt_r.opcode;
      tv_index_r      <= tl_index;
      tv_offset_r     <= tl_pkt_r.page_offset[`OFFSET_WIDTH-1:0];
      tv_store_data_r <= tl_pkt_r.data;
      tv_ptag_r       <= ptag_i;
      tv_tag_r        <= tag_mem[tl_index];
      tv_valid_r      <= valid_r[tl_index];
      tv_data_r       <= tl_rd_data;
      if (miss_v_o)
         miss_paddr_r <= miss_paddr_o;
      if (store_hit)
         data_mem[tv_index_r] <= tv_store_data_r;
      if (fill_v_i)
      begin
         data_mem[miss_paddr_r.fields.index] <= fill_data_i;
         tag_mem[miss_paddr_r.fields.index]  <= miss_paddr_r.fields.ptag;
      end
   end

endmodule

// File: logic/miss_engine.sv
//////////////////////////////
// Memory command and response
// sequencing for fills and stores
//////////////////////////////

`timescale 1ns/1ps
`include "dcache_macros.svh"

module miss_engine
   import mem_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   input  logic                     miss_v_i,
   input  mem_paddr_u               miss_paddr_i,
   input  logic                     store_v_i,
   input  mem_paddr_u               store_paddr_i,
   input  logic [`DWORD_WIDTH-1:0]  store_data_i,
   output logic                     busy_o,
   output logic                     fill_v_o,
   output logic [`DWORD_WIDTH-1:0]  fill_data_o,

   output mem_header_s              mem_cmd_header_o,
   output logic [`DWORD_WIDTH-1:0]  mem_cmd_data_o,
   output logic                     mem_cmd_v_o,
   input  logic                     mem_cmd_ready_and_i,

   input  mem_header_s              mem_resp_header_i,
   input  logic [`DWORD_WIDTH-1:0]  mem_resp_data_i,
   input  logic                     mem_resp_v_i,
   output logic                     mem_resp_ready_and_o
);

   typedef enum logic [1:0] {ST_IDLE, ST_CMD, ST_RESP} state_e;

   state_e state_r;
   logic   req_v;

   assign req_v = (state_r == ST_IDLE) & (miss_v_i | store_v_i);

   assign busy_o               = (state_r != ST_IDLE);
   assign mem_cmd_v_o          = (state_r == ST_CMD);
   assign mem_resp_ready_and_o = (state_r == ST_RESP);

   // Write responses carry nothing back to the cache
   assign fill_v_o    = mem_resp_ready_and_o & mem_resp_v_i
                      & (mem_resp_header_i.op == MEM_OP_RD);
   assign fill_data_o = mem_resp_data_i;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         state_r <= ST_IDLE;
      else
      begin
         case (state_r)
            ST_IDLE: if (req_v) state_r <= ST_CMD;
            ST_CMD:  if (mem_cmd_ready_and_i) state_r <= ST_RESP;
            ST_RESP: if (mem_resp_v_i) state_r <= ST_IDLE;
            default: state_r <= ST_IDLE;
         endcase
      end
   end

   // Held until the command is taken
   always_ff @(posedge clk_i)
   begin
      if (req_v)
      begin
         mem_cmd_header_o.op   <= miss_v_i ? MEM_OP_RD : MEM_OP_WR;
         mem_cmd_header_o.addr <= miss_v_i ? miss_paddr_i : store_paddr_i;
         mem_cmd_data_o        <= miss_v_i ? '0 : store_data_i;
      end
   end

endmodule

// File: logic/dcache_top.sv
//////////////////////////////
// Cache top, replay tracking
//////////////////////////////

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top
   import dcache_pkg::*, mem_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   input  dcache_pkt_s              pkt_i,
   input  logic [`PTAG_WIDTH-1:0]   ptag_i,
   input  logic                     v_i,
   output logic                     ready_o,
   output logic [`DWORD_WIDTH-1:0]  data_o,
   output logic                     v_o,

   output mem_header_s              mem_cmd_header_o,
   output logic [`DWORD_WIDTH-1:0]  mem_cmd_data_o,
   output logic                     mem_cmd_v_o,
   input  logic                     mem_cmd_ready_and_i,
   input  mem_header_s              mem_resp_header_i,
   input  logic [`DWORD_WIDTH-1:0]  mem_resp_data_i,
   input  logic                     mem_resp_v_i,
   output logic                     mem_resp_ready_and_o
);

   dcache_pkt_s              fifo_pkt;
   logic [`PTAG_WIDTH-1:0]   fifo_ptag;
   logic [`PTAG_WIDTH-1:0]   ptag_r;
   logic                     issue, issue_r, issue_rr;
   logic                     retire, roll;
   logic                     cache_ready, engine_busy;
   logic                     miss_v, store_v, fill_v;
   mem_paddr_u               miss_paddr, store_paddr;
   logic [`DWORD_WIDTH-1:0]  store_data, fill_data;

   // Issue strobe lined up with tag verify
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         issue_r  <= 1'b0;
         issue_rr <= 1'b0;
      end
      else
      begin
         issue_r  <= issue;
         issue_rr <= issue_r;
      end
   end

   // Tag arrives with the op in tag lookup
   always_ff @(posedge clk_i)
      ptag_r <= fifo_ptag;

   assign roll   = issue_rr & ~v_o;
   assign retire = issue_rr & v_o;

   replay_fifo u_fifo
   (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .pkt_i(pkt_i), .ptag_i(ptag_i), .v_i(v_i), .ready_o(ready_o),
      .pkt_o(fifo_pkt), .ptag_o(fifo_ptag), .issue_o(issue),
      .issue_ready_i(cache_ready), .retire_i(retire), .roll_i(roll)
   );

   dcache u_dcache
   (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .pkt_i(fifo_pkt), .v_i(issue), .ready_o(cache_ready), .ptag_i(ptag_r),
      .data_o(data_o), .v_o(v_o), .engine_busy_i(engine_busy),
      .miss_v_o(miss_v), .miss_paddr_o(miss_paddr),
      .store_v_o(store_v), .store_paddr_o(store_paddr), .store_data_o(store_data),
      .fill_v_i(fill_v), .fill_data_i(fill_data)
   );

   miss_engine u_engine
   (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .miss_v_i(miss_v), .miss_paddr_i(miss_paddr),
      .store_v_i(store_v), .store_paddr_i(store_paddr), .store_data_i(store_data),
      .busy_o(engine_busy), .fill_v_o(fill_v), .fill_data_o(fill_data),
      .mem_cmd_header_o(mem_cmd_header_o), .mem_cmd_data_o(mem_cmd_data_o),
      .mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_ready_and_i(mem_cmd_ready_and_i),
      .mem_resp_header_i(mem_resp_header_i), .mem_resp_data_i(mem_resp_data_i),
      .mem_resp_v_i(mem_resp_v_i), .mem_resp_ready_and_o(mem_resp_ready_and_o)
   );

endmodule

// File: dv/dcache_assertions.sv
//////////////////////////////
// Memory command and reset
// protocol assertions
//////////////////////////////

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_assertions
   import mem_pkg::*;
(
   input logic                     clk_i,
   input logic                     rst_n_i,
   input logic                     v_i,
   input logic                     cmd_v_i,
   input logic                     cmd_ready_i,
   input mem_header_s              cmd_header_i,
   input logic [`DWORD_WIDTH-1:0]  cmd_data_i
);

   int fail_count = 0;

   // Command held stable until taken
   cmd_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_v_i && !cmd_ready_i |=> cmd_v_i && $stable(cmd_header_i) && $stable(cmd_data_i))
   else
   begin
      $error("Memory command changed before it was taken");
      fail_count++;
   end

   result_in_reset_a: assert property (@(posedge clk_i) !rst_n_i |-> !v_i)
   else
   begin
      $error("Result valid while in reset");
      fail_count++;
   end

   cmd_in_reset_a: assert property (@(posedge clk_i) !rst_n_i |-> !cmd_v_i)
   else
   begin
      $error("Memory command valid while in reset");
      fail_count++;
   end

endmodule

bind dcache_top dcache_assertions u_assertions
(
   .clk_i(clk_i), .rst_n_i(rst_n_i), .v_i(v_o), .cmd_v_i(mem_cmd_v_o),
   .cmd_ready_i(mem_cmd_ready_and_i), .cmd_header_i(mem_cmd_header_o),
   .cmd_data_i(mem_cmd_data_o)
);

// File: dv/dcache_tb.sv
//////////////////////////////
// Cache testbench, memory model
// reference and result checker
//////////////////////////////

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tb
   import dcache_pkg::*, mem_pkg::*;
();

   localparam int TIMEOUT = 2000;

   logic                    clk_i = 1'b0;
   logic                    rst_n_i;
   dcache_pkt_s             pkt_i;
   logic [`PTAG_WIDTH-1:0]  ptag_i;
   logic                    v_i;
   logic                    ready_o;
   logic [`DWORD_WIDTH-1:0] data_o;
   logic                    v_o;
   mem_header_s             mem_cmd_header_o;
   logic [`DWORD_WIDTH-1:0] mem_cmd_data_o;
   logic                    mem_cmd_v_o;
   logic                    mem_cmd_ready_and_i;
   mem_header_s             mem_resp_header_i;
   logic [`DWORD_WIDTH-1:0] mem_resp_data_i;
   logic                    mem_resp_v_i;
   logic                    mem_resp_ready_and_o;

   integer                  seed = 41;
   logic                    bp_en = 1'b0;
   logic [`DWORD_WIDTH-1:0] shadow    [logic [`PADDR_WIDTH-1:0]];
   logic [`DWORD_WIDTH-1:0] mem_words [logic [`PADDR_WIDTH-1:0]];
   logic [`DWORD_WIDTH-1:0] expect_q  [$];
   logic [`DWORD_WIDTH-1:0] exp_word;
   mem_header_s             cmd_hdr;
   logic [`DWORD_WIDTH-1:0] cmd_data;
   logic                    cmd_seen = 1'b0;
   logic                    resp_taken = 1'b0;
   logic                    resp_pend = 1'b0;
   int                      resp_wait;
   int                      read_cmds = 0;
   int                      write_cmds = 0;

   dcache_top UUT (.*);

   always #2 clk_i = ~clk_i;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
         abort_run($sformatf("[FAIL] %s = %h, expected %h", name, got, exp));
   endtask

   // Words never written read back as this
   function automatic logic [`DWORD_WIDTH-1:0] mem_pattern(input logic [`PADDR_WIDTH-1:0] addr);
      return {addr ^ 32'h5eed_c0de, ~addr};
   endfunction

   function automatic logic [`DWORD_WIDTH-1:0] expected_result(input dcache_op_e op,
      input logic [`PADDR_WIDTH-1:0] addr, input logic [`DWORD_WIDTH-1:0] data);
      if (op == DCACHE_OP_SD)
      begin
         shadow[addr] = data;
         return '0;
      end
      return shadow.exists(addr) ? shadow[addr] : mem_pattern(addr);
   endfunction

   task automatic send_op(input dcache_op_e op, input logic [`PTAG_WIDTH-1:0] ptag,
                          input logic [`PAGE_OFFSET_WIDTH-1:0] offs,
                          input logic [`DWORD_WIDTH-1:0] data);
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      pkt_i  = '{opcode: op, page_offset: offs, data: data};
      ptag_i = ptag;
      v_i    = 1'b1;
      @(posedge clk_i);
      while (!ready_o)
      begin
         cycles++;
         assert (cycles < TIMEOUT) else abort_run("Operation was never accepted");
         @(posedge clk_i);
      end
      expect_q.push_back(expected_result(op, {ptag, offs}, data));
   endtask

   task automatic drain_results();
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      v_i = 1'b0;
      while (expect_q.size() != 0)
      begin
         cycles++;
         assert (cycles < TIMEOUT) else abort_run("Results stopped coming out");
         @(negedge clk_i);
      end
   endtask

   task automatic wait_writes(input int target);
      int cycles;
      cycles = 0;
      while (write_cmds < target)
      begin
         cycles++;
         assert (cycles < TIMEOUT) else abort_run("Write command never reached memory");
         @(negedge clk_i);
      end
   endtask

   // Command capture on the memory side
   always @(posedge clk_i)
   begin
      if (mem_cmd_v_o && mem_cmd_ready_and_i)
      begin
         cmd_hdr  = mem_cmd_header_o;
         cmd_data = mem_cmd_data_o;
         cmd_seen = 1'b1;
         if (mem_cmd_header_o.op == MEM_OP_RD)
            read_cmds++;
         else
            write_cmds++;
      end
      if (mem_resp_v_i && mem_resp_ready_and_o)
         resp_taken = 1'b1;
   end

   // One response per command after a random delay
   always @(negedge clk_i)
   begin
      if (resp_taken)
      begin
         mem_resp_v_i = 1'b0;
         resp_taken   = 1'b0;
         resp_pend    = 1'b0;
      end
      if (cmd_seen)
      begin
         cmd_seen = 1'b0;
         if (cmd_hdr.op == MEM_OP_WR)
            mem_words[cmd_hdr.addr.raw] = cmd_data;
         mem_resp_header_i = cmd_hdr;
         mem_resp_data_i   = mem_words.exists(cmd_hdr.addr.raw) ? mem_words[cmd_hdr.addr.raw]
                                                              : mem_pattern(cmd_hdr.addr.raw);
         resp_wait = $random(seed) & 3;
         resp_pend = 1'b1;
      end
      else if (resp_pend && !mem_resp_v_i)
      begin
         if (resp_wait == 0)
            mem_resp_v_i = 1'b1;
         else
            resp_wait--;
      end
      mem_cmd_ready_and_i = bp_en ? (($random(seed) & 3) == 0) : 1'b1;
   end

   always @(posedge clk_i)
   begin
      assert (UUT.u_assertions.fail_count == 0) else abort_run("A protocol assertion failed");
      if (rst_n_i && v_o)
      begin
         assert (expect_q.size() != 0) else abort_run("Result came out with nothing pending");
         exp_word = expect_q.pop_front();
         check_value("data_o", data_o, exp_word);
      end
   end

   initial
   begin
      int                            base_reads;
      int                            base_writes;
      dcache_op_e                    rnd_op;
      logic [`PTAG_WIDTH-1:0]        rnd_ptag;
      logic [`PAGE_OFFSET_WIDTH-1:0] rnd_offs;
      rst_n_i             = 1'b0;
      v_i                 = 1'b0;
      pkt_i               = '0;
      ptag_i              = '0;
      mem_cmd_ready_and_i = 1'b0;
      mem_resp_v_i        = 1'b0;
      mem_resp_header_i   = '0;
      mem_resp_data_i     = '0;
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      @(negedge clk_i);
      check_value("v_o", v_o, 0);
      check_value("mem_cmd_v_o", mem_cmd_v_o, 0);
      check_value("mem_resp_ready_and_o", mem_resp_ready_and_o, 0);
      check_value("ready_o", ready_o, 1);

      // First load misses, the repeat hits
      base_reads = read_cmds;
      send_op(DCACHE_OP_LD, 20'h12345, 12'h208, '0);
      drain_results();
      check_value("read commands", read_cmds - base_reads, 1);
      send_op(DCACHE_OP_LD, 20'h12345, 12'h208, '0);
      drain_results();
      check_value("read commands", read_cmds - base_reads, 1);

      base_writes = write_cmds;
      send_op(DCACHE_OP_SD, 20'h12345, 12'h208, 64'hfeed_beef_0123_4567);
      drain_results();
      wait_writes(base_writes + 1);
      check_value("write address", cmd_hdr.addr.raw, {20'h12345, 12'h208});
      check_value("write data", cmd_data, 64'hfeed_beef_0123_4567);
      send_op(DCACHE_OP_LD, 20'h12345, 12'h208, '0);
      send_op(DCACHE_OP_SD, 20'h0abcd, 12'h010, 64'h1111_2222_3333_4444);
      send_op(DCACHE_OP_LD, 20'h0abcd, 12'h010, '0);
      drain_results();

      // Two tags fighting over one set
      base_reads = read_cmds;
      for (int i = 0; i < 6; i++)
         send_op(DCACHE_OP_LD, (i % 2) ? 20'h00077 : 20'h00099, 12'h5f8, '0);
      drain_results();
      check_value("read commands", read_cmds - base_reads, 6);

      bp_en = 1'b1;
      for (int i = 0; i < 300; i++)
      begin
         rnd_op   = ($random(seed) & 1) ? DCACHE_OP_SD : DCACHE_OP_LD;
         rnd_ptag = 20'h00100 + ($random(seed) & 3);
         rnd_offs = 12'(($random(seed) & 7) << 3);
         send_op(rnd_op, rnd_ptag, rnd_offs, {$random(seed), $random(seed)});
      end
      drain_results();

      if (UUT.u_assertions.fail_count == 0)
      begin
         $display("*** PASSED ***");
         $finish;
      end
      else
         abort_run("Protocol assertions failed during the run");
   end

endmodule

// File: list.f
+incdir+logic
logic/dcache_pkg.sv
logic/mem_pkg.sv
logic/replay_fifo.sv
logic/dcache.sv
logic/miss_engine.sv
logic/dcache_top.sv
dv/dcache_assertions.sv
dv/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - logic
    files:
      - logic/dcache_pkg.sv
      - logic/mem_pkg.sv
      - logic/replay_fifo.sv
      - logic/dcache.sv
      - logic/miss_engine.sv
      - logic/dcache_top.sv
      - target: simulation
        files:
          - dv/dcache_assertions.sv
          - dv/dcache_tb.sv
